// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, log to sim.log"
	@echo "  clean  remove obj_dir and sim.log"

test:
	verilator --binary --timing --top-module preview_tb -f tb.f -o preview_sim
	./obj_dir/preview_sim > sim.log 2>&1 || true
	cat sim.log
	! grep -q "test failed" sim.log
	grep -q "test passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== dv/preview_props.sv ====
`timescale 1ns/1ns

module preview_props (
    input logic                     core_clk,
    input logic                     sys_reset,
    input logic                     tx_valid_o,
    input logic                     tx_stall_i,
    input preview_pkg::pixel_t      tx_byte_o,
    input logic                     pop_o,
    input preview_pkg::pixel_beat_t beat_i
);

    // host link holds its byte while stalled
    stalled_byte_held: assert property (
        @(posedge core_clk) disable iff (sys_reset)
            (tx_stall_i && !pop_o) |=> $stable(tx_byte_o)
    ) else $error("tx_byte_o changed while tx_stall_i was holding it");

    valid_after_reset: assert property (
        @(posedge core_clk) sys_reset |=> !tx_valid_o
    ) else $error("tx_valid_o high in the cycle after reset");

    // a fetched frame start opens with the first header byte
    header_after_sof: assert property (
        @(posedge core_clk) disable iff (sys_reset)
            (pop_o && beat_i.sof) |=> (tx_byte_o == preview_pkg::MAGIC_NUM[63:56])
    ) else $error("first header byte missing after a frame start was fetched");

endmodule

bind frame_serializer preview_props preview_props_i (
    .core_clk   (core_clk),
    .sys_reset  (sys_reset),
    .tx_valid_o (tx_valid_o),
    .tx_stall_i (tx_stall_i),
    .tx_byte_o  (tx_byte_o),
    .pop_o      (pop_o),
    .beat_i     (beat_i)
);

// ==== dv/preview_tb.sv ====
`timescale 1ns/1ns

module preview_tb;

    localparam int DRAIN_TIMEOUT = 2000;

    logic                     core_clk;
    logic                     sys_reset;
    preview_pkg::pixel_t      byte_i;
    logic                     byte_valid_i;
    preview_pkg::pixel_pair_t pixel_i;
    logic                     pixel_valid_i;
    logic                     pixel_sof_i;
    logic                     tx_stall_i;
    preview_pkg::pixel_t      tx_byte_o;
    logic                     tx_valid_o;
    logic                     overflow_o;

    // reference model state
    preview_pkg::pixel_t exp_q[$];
    int                  model_crop;
    logic [1:0]          model_mask;

    preview_top preview_top_i (
        .core_clk      (core_clk),
        .sys_reset     (sys_reset),
        .byte_i        (byte_i),
        .byte_valid_i  (byte_valid_i),
        .pixel_i       (pixel_i),
        .pixel_valid_i (pixel_valid_i),
        .pixel_sof_i   (pixel_sof_i),
        .tx_stall_i    (tx_stall_i),
        .tx_byte_o     (tx_byte_o),
        .tx_valid_o    (tx_valid_o),
        .overflow_o    (overflow_o)
    );

    always #10 core_clk = ~core_clk;

    //////////////////////////////
    // error handling and compares
    //////////////////////////////

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_byte(input preview_pkg::pixel_t got, input preview_pkg::pixel_t exp);
        if (got !== exp) begin
            abort_run($sformatf("FAIL %0t: host byte %02h, expected %02h", $time, got, exp));
        end
    endtask

    task automatic check_overflow(input logic got);
        if (got !== 1'b0) begin
            abort_run($sformatf("FAIL %0t: overflow flag %b, expected 0", $time, got));
        end
    endtask

    // outputs settle well before the falling edge
    always @(negedge core_clk) begin
        if (!sys_reset) begin
            check_overflow(overflow_o);
            if (tx_valid_o) begin
                if (exp_q.size() == 0) begin
                    abort_run($sformatf("host link sent byte %02h at %0t with none expected",
                                        tx_byte_o, $time));
                end else begin
                    check_byte(tx_byte_o, exp_q.pop_front());
                end
            end
        end
    end

    //////////////////////////////
    // stimulus and model
    //////////////////////////////

    // random stall about one cycle in four
    task automatic next_cycle();
        @(posedge core_clk);
        #2;
        tx_stall_i = ($urandom_range(3) == 0);
    endtask

    task automatic model_pixel(input int row, input int col, input preview_pkg::pixel_pair_t px);
        if (col >= model_crop && col < model_crop + preview_pkg::CROP_WIDTH) begin
            if (row == 0 && col == model_crop) begin
                for (int i = 0; i < 8; i++) begin
                    exp_q.push_back(preview_pkg::MAGIC_NUM[63-8*i -: 8]);
                end
            end
            if (model_mask[0]) begin
                exp_q.push_back(px.ch0);
            end
            if (model_mask[1]) begin
                exp_q.push_back(px.ch1);
            end
        end
    endtask

    task automatic send_frame();
        preview_pkg::pixel_pair_t px;
        for (int row = 0; row < preview_pkg::FRAME_HEIGHT; row++) begin
            for (int col = 0; col < preview_pkg::FRAME_WIDTH; col++) begin
                // idle gaps, roughly two cycles in three
                while ($urandom_range(2) != 0) begin
                    pixel_valid_i = 1'b0;
                    pixel_sof_i   = 1'b0;
                    next_cycle();
                end
                px.ch0        = 8'($urandom);
                px.ch1        = 8'($urandom);
                pixel_i       = px;
                pixel_valid_i = 1'b1;
                pixel_sof_i   = (row == 0) && (col == 0);
                model_pixel(row, col, px);
                next_cycle();
            end
        end
        pixel_valid_i = 1'b0;
        pixel_sof_i   = 1'b0;
    endtask

    task automatic send_cmd(input logic [15:0] addr, input logic [31:0] data);
        preview_pkg::cmd_word_t cmd;
        cmd.addr = addr;
        cmd.data = data;
        for (int i = preview_pkg::CMD_BYTES - 1; i >= 0; i--) begin
            byte_i       = cmd[8*i +: 8];
            byte_valid_i = 1'b1;
            next_cycle();
            byte_valid_i = 1'b0;
            next_cycle();
        end
        if (addr == preview_pkg::ADDR_CROP_COL) begin
            model_crop = int'(data[15:0]);
        end else if (addr == preview_pkg::ADDR_CHAN_MASK) begin
            model_mask = data[1:0];
        end
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0) begin
            if (cycles == DRAIN_TIMEOUT) begin
                abort_run("timeout: expected bytes never left the host link");
            end else begin
                next_cycle();
                cycles++;
            end
        end
    endtask

    initial begin
        int crop;
        core_clk      = 1'b0;
        sys_reset     = 1'b1;
        byte_i        = '0;
        byte_valid_i  = 1'b0;
        pixel_i       = '0;
        pixel_valid_i = 1'b0;
        pixel_sof_i   = 1'b0;
        tx_stall_i    = 1'b0;
        model_crop    = int'(preview_pkg::DEFAULT_CROP_COL);
        model_mask    = preview_pkg::DEFAULT_CHAN_MASK;
        void'($urandom(32'hcfc2_2611));
        repeat (4) @(posedge core_clk);
        #2;
        sys_reset = 1'b0;

        // default window, both channels
        repeat (2) begin
            send_frame();
            wait_drain();
        end

        // moved and clipped windows
        repeat (3) begin
            crop = $urandom_range(6);
            send_cmd(preview_pkg::ADDR_CROP_COL, 32'(crop));
            send_frame();
            wait_drain();
        end
        send_cmd(preview_pkg::ADDR_CROP_COL, 32'd8);
        send_frame();
        wait_drain();
        send_cmd(preview_pkg::ADDR_CROP_COL, 32'(preview_pkg::DEFAULT_CROP_COL));

        // ch0 only, ch1 only, header alone
        send_cmd(preview_pkg::ADDR_CHAN_MASK, 32'd1);
        send_frame();
        wait_drain();
        send_cmd(preview_pkg::ADDR_CHAN_MASK, 32'd2);
        send_frame();
        wait_drain();
        send_cmd(preview_pkg::ADDR_CHAN_MASK, 32'd0);
        send_frame();
        wait_drain();
        send_cmd(preview_pkg::ADDR_CHAN_MASK, 32'd3);

        // unused address
        send_cmd(16'h0012, $urandom);
        send_frame();
        wait_drain();

        if (overflow_o !== 1'b0) begin
            abort_run("pixel buffer overflowed during the run");
        end else begin
            $display("test passed");
            $finish;
        end
    end

endmodule

// ==== logic/cmd_decoder.sv ====
`timescale 1ns/1ns

module cmd_decoder (
    input  logic                      core_clk,
    input  logic                      sys_reset,
    input  preview_pkg::pixel_t       byte_i,
    input  logic                      byte_valid_i,
    output preview_pkg::preview_cfg_t cfg_o
);

    preview_pkg::cmd_word_t shift_q;
    preview_pkg::cmd_word_t cmd_next;
    preview_pkg::cmd_cnt_t  count_q;
    logic                   last_byte;

    // newest byte enters at the bottom
    assign cmd_next  = preview_pkg::cmd_word_t'({shift_q[39:0], byte_i});
    assign last_byte = byte_valid_i &&
                       (count_q == preview_pkg::cmd_cnt_t'(preview_pkg::CMD_BYTES - 1));

    always_ff @(posedge core_clk) begin
        if (byte_valid_i) begin
            shift_q <= cmd_next;
        end
    end

    //////////////////////////////
    // byte count
    //////////////////////////////

    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            count_q <= '0;
        end else if (last_byte) begin
            count_q <= '0;
        end else if (byte_valid_i) begin
            count_q <= count_q + 1'b1;
        end
    end

    //////////////////////////////
    // constant registers
    //////////////////////////////

    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            cfg_o.crop_col  <= preview_pkg::DEFAULT_CROP_COL;
            cfg_o.chan_mask <= preview_pkg::DEFAULT_CHAN_MASK;
        end else if (last_byte) begin
            case (cmd_next.addr)
                preview_pkg::ADDR_CROP_COL: begin
                    cfg_o.crop_col <= cmd_next.data[15:0];
                end
                preview_pkg::ADDR_CHAN_MASK: begin
                    cfg_o.chan_mask <= cmd_next.data[1:0];
                end
                default: begin
                    // unknown address, command ignored
                end
            endcase
        end
    end

endmodule

// ==== logic/frame_serializer.sv ====
`timescale 1ns/1ns

module frame_serializer (
    input  logic                      core_clk,
    input  logic                      sys_reset,
    input  preview_pkg::pixel_beat_t  beat_i,
    input  logic                      empty_i,
    output logic                      pop_o,
    input  preview_pkg::preview_cfg_t cfg_i,
    input  logic                      tx_stall_i,
    output preview_pkg::pixel_t       tx_byte_o,
    output logic                      tx_valid_o
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_MAGIC,
        S_CH0,
        S_CH1
    } state_t;

    state_t                   state_q;
    preview_pkg::pixel_beat_t beat_q;
    logic [63:0]              magic_q;
    logic [2:0]               magic_idx_q;
    logic                     last_byte;

    // first channel state for a mask, idle when nothing is enabled
    function automatic state_t chan_start(input logic [1:0] mask);
        if (mask[0]) begin
            return S_CH0;
        end else if (mask[1]) begin
            return S_CH1;
        end
        return S_IDLE;
    endfunction

    //////////////////////////////
    // output side
    //////////////////////////////

    assign tx_valid_o = (state_q != S_IDLE) && !tx_stall_i;

    always_comb begin
        case (state_q)
            S_MAGIC: last_byte = (magic_idx_q == 3'd7) && (cfg_i.chan_mask == 2'b00);
            S_CH0:   last_byte = !cfg_i.chan_mask[1];
            S_CH1:   last_byte = 1'b1;
            default: last_byte = 1'b0;
        endcase
    end

    always_comb begin
        case (state_q)
            S_MAGIC: tx_byte_o = magic_q[63:56];
            S_CH0:   tx_byte_o = beat_q.pair.ch0;
            S_CH1:   tx_byte_o = beat_q.pair.ch1;
            default: tx_byte_o = '0;
        endcase
    end

    // next beat is fetched while the last byte of this one goes out
    assign pop_o = !empty_i && ((state_q == S_IDLE) || (tx_valid_o && last_byte));

    //////////////////////////////
    // sequencing
    //////////////////////////////

    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            state_q     <= S_IDLE;
            magic_idx_q <= '0;
        end else if (pop_o) begin
            magic_idx_q <= '0;
            state_q     <= beat_i.sof ? S_MAGIC : chan_start(cfg_i.chan_mask);
        end else if (tx_valid_o) begin
            case (state_q)
                S_MAGIC: begin
                    magic_idx_q <= magic_idx_q + 1'b1;
                    if (magic_idx_q == 3'd7) begin
                        state_q <= chan_start(cfg_i.chan_mask);
                    end
                end
                S_CH0: begin
                    state_q <= cfg_i.chan_mask[1] ? S_CH1 : S_IDLE;
                end
                default: begin
                    state_q <= S_IDLE;
                end
            endcase
        end
    end

    // header bytes shift out msb first
    always_ff @(posedge core_clk) begin
        if (pop_o) begin
            beat_q  <= beat_i;
            magic_q <= preview_pkg::MAGIC_NUM;
        end else if (tx_valid_o && (state_q == S_MAGIC)) begin
            magic_q <= magic_q << 8;
        end
    end

endmodule

// ==== logic/pixel_cropper.sv ====
`timescale 1ns/1ns

module pixel_cropper (
    input  logic                      core_clk,
    input  logic                      sys_reset,
    input  preview_pkg::pixel_pair_t  pixel_i,
    input  logic                      pixel_valid_i,
    input  logic                      pixel_sof_i,
    input  preview_pkg::preview_cfg_t cfg_i,
    output preview_pkg::pixel_beat_t  beat_o,
    output logic                      push_o
);

    preview_pkg::coord_t col_q;
    preview_pkg::coord_t row_q;
    preview_pkg::coord_t cur_col;
    preview_pkg::coord_t cur_row;
    logic [16:0]         win_end;
    logic                in_window;

    // position of the pixel on the input right now
    assign cur_col = pixel_sof_i ? '0 : col_q;
    assign cur_row = pixel_sof_i ? '0 : row_q;

    // one bit wider so a late window start cannot wrap
    assign win_end   = {1'b0, cfg_i.crop_col} + 17'(preview_pkg::CROP_WIDTH);
    assign in_window = (cur_col >= cfg_i.crop_col) && ({1'b0, cur_col} < win_end);

    //////////////////////////////
    // row and column tracking
    //////////////////////////////

    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            col_q <= '0;
            row_q <= '0;
        end else if (pixel_valid_i) begin
            if (cur_col == preview_pkg::coord_t'(preview_pkg::FRAME_WIDTH - 1)) begin
                col_q <= '0;
                if (cur_row == preview_pkg::coord_t'(preview_pkg::FRAME_HEIGHT - 1)) begin
                    row_q <= '0;
                end else begin
                    row_q <= cur_row + 1'b1;
                end
            end else begin
                col_q <= cur_col + 1'b1;
                row_q <= cur_row;
            end
        end
    end

    //////////////////////////////
    // kept beat
    //////////////////////////////

    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            push_o <= 1'b0;
        end else begin
            push_o <= pixel_valid_i && in_window;
        end
    end

    // first kept pixel of row 0 opens the frame
    always_ff @(posedge core_clk) begin
        beat_o.pair <= pixel_i;
        beat_o.sof  <= (cur_row == '0) && (cur_col == cfg_i.crop_col);
    end

endmodule

// ==== logic/pixel_fifo.sv ====
`timescale 1ns/1ns

module pixel_fifo (
    input  logic                     core_clk,
    input  logic                     sys_reset,
    input  preview_pkg::pixel_beat_t beat_i,
    input  logic                     push_i,
    input  logic                     pop_i,
    output preview_pkg::pixel_beat_t beat_o,
    output logic                     empty_o,
    output logic                     overflow_o
);

    preview_pkg::pixel_beat_t mem_q [preview_pkg::FIFO_DEPTH];

    // extra msb tells full from empty
    preview_pkg::fifo_ptr_t wr_ptr_q;
    preview_pkg::fifo_ptr_t rd_ptr_q;
    logic                   full;
    logic                   do_push;
    logic                   do_pop;

    localparam int AW = preview_pkg::FIFO_ADDR_W;

    assign empty_o = (wr_ptr_q == rd_ptr_q);
    assign full    = (wr_ptr_q[AW] != rd_ptr_q[AW]) &&
                     (wr_ptr_q[AW-1:0] == rd_ptr_q[AW-1:0]);
    assign do_push = push_i && !full;
    assign do_pop  = pop_i && !empty_o;

    assign beat_o = mem_q[rd_ptr_q[AW-1:0]];

    always_ff @(posedge core_clk) begin
        if (do_push) begin
            mem_q[wr_ptr_q[AW-1:0]] <= beat_i;
        end
    end

    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            wr_ptr_q   <= '0;
            rd_ptr_q   <= '0;
            overflow_o <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            // sticky until reset
            if (push_i && full) begin
                overflow_o <= 1'b1;
            end
        end
    end

endmodule

// ==== logic/preview_pkg.sv ====
package preview_pkg;

    //////////////////////////////
    // frame geometry
    //////////////////////////////

    localparam int FRAME_WIDTH  = 16;
    localparam int FRAME_HEIGHT = 8;
    localparam int CROP_WIDTH   = 12;

    // kept pixel buffer
    localparam int FIFO_DEPTH  = 32;
    localparam int FIFO_ADDR_W = $clog2(FIFO_DEPTH);

    //////////////////////////////
    // host command format
    //////////////////////////////

    // 2 address bytes then 4 data bytes, most significant first
    localparam int CMD_BYTES = 6;
    localparam int CMD_CNT_W = $clog2(CMD_BYTES);

    localparam logic [15:0] ADDR_CROP_COL  = 16'h0010;
    localparam logic [15:0] ADDR_CHAN_MASK = 16'h0011;

    // "BIVFRAME", sent msb first
    localparam logic [63:0] MAGIC_NUM = 64'h4249_5646_5241_4D45;

    //////////////////////////////
    // types
    //////////////////////////////

    typedef logic [7:0]  pixel_t;
    typedef logic [15:0] coord_t;

    typedef logic [CMD_CNT_W-1:0] cmd_cnt_t;
    typedef logic [FIFO_ADDR_W:0] fifo_ptr_t;

    typedef struct packed {
        pixel_t ch1;
        pixel_t ch0;
    } pixel_pair_t;

    typedef struct packed {
        pixel_pair_t pair;
        logic        sof;
    } pixel_beat_t;

    typedef struct packed {
        logic [15:0] addr;
        logic [31:0] data;
    } cmd_word_t;

    typedef struct packed {
        coord_t     crop_col;
        logic [1:0] chan_mask;
    } preview_cfg_t;

    // reset values of the run-time constants
    localparam coord_t     DEFAULT_CROP_COL  = coord_t'((FRAME_WIDTH - CROP_WIDTH) / 2);
    localparam logic [1:0] DEFAULT_CHAN_MASK = 2'b11;

endpackage

// ==== logic/preview_top.sv ====
`timescale 1ns/1ns

module preview_top (
    input  logic                     core_clk,
    input  logic                     sys_reset,
    input  preview_pkg::pixel_t      byte_i,
    input  logic                     byte_valid_i,
    input  preview_pkg::pixel_pair_t pixel_i,
    input  logic                     pixel_valid_i,
    input  logic                     pixel_sof_i,
    input  logic                     tx_stall_i,
    output preview_pkg::pixel_t      tx_byte_o,
    output logic                     tx_valid_o,
    output logic                     overflow_o
);

    preview_pkg::preview_cfg_t cfg;
    preview_pkg::pixel_beat_t  kept_beat;
    preview_pkg::pixel_beat_t  head_beat;
    logic                      push;
    logic                      pop;
    logic                      empty;

    cmd_decoder cmd_decoder_i (
        .core_clk     (core_clk),
        .sys_reset    (sys_reset),
        .byte_i       (byte_i),
        .byte_valid_i (byte_valid_i),
        .cfg_o        (cfg)
    );

    pixel_cropper pixel_cropper_i (
        .core_clk      (core_clk),
        .sys_reset     (sys_reset),
        .pixel_i       (pixel_i),
        .pixel_valid_i (pixel_valid_i),
        .pixel_sof_i   (pixel_sof_i),
        .cfg_i         (cfg),
        .beat_o        (kept_beat),
        .push_o        (push)
    );

    // absorbs pixels while the host link stalls
    pixel_fifo pixel_fifo_i (
        .core_clk   (core_clk),
        .sys_reset  (sys_reset),
        .beat_i     (kept_beat),
        .push_i     (push),
        .pop_i      (pop),
        .beat_o     (head_beat),
        .empty_o    (empty),
        .overflow_o (overflow_o)
    );

    frame_serializer frame_serializer_i (
        .core_clk   (core_clk),
        .sys_reset  (sys_reset),
        .beat_i     (head_beat),
        .empty_i    (empty),
        .pop_o      (pop),
        .cfg_i      (cfg),
        .tx_stall_i (tx_stall_i),
        .tx_byte_o  (tx_byte_o),
        .tx_valid_o (tx_valid_o)
    );

endmodule

// ==== tb.f ====
logic/preview_pkg.sv
logic/cmd_decoder.sv
logic/pixel_cropper.sv
logic/pixel_fifo.sv
logic/frame_serializer.sv
logic/preview_top.sv
dv/preview_props.sv
dv/preview_tb.sv
